/* Makefile */
TOP = tb_lab7

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

# $fatal in the testbench gives a non-zero exit status
sim:
	verilator --binary --timing --assert -j 0 -f sources.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* sim/lab7_patterns.txt */
// One test per line, all hex, presses are cumulative across lines
// sw   up down left right centre  shifted  led
a5c3  0 0 0 0 0  a5c3 00
1234  0 0 1 0 0  2468 04
8001  0 0 0 1 0  0008 0c
00f0  1 0 0 0 0  001e 0d
ffff  0 0 0 0 1  01ff 1d
abcd  0 0 0 0 1  0015 2d
8000  0 0 0 0 1  0001 3d
ffff  1 0 0 0 0  8000 3c
1234  0 1 0 0 0  091a 3e
1234  0 0 0 0 1  91a0 0e
f00f  0 0 1 0 0  c03f 0a
f00f  1 0 0 0 0  fc03 0b
beef  0 0 0 1 2  efbe 23
1357  0 1 1 0 0  0009 25
c001  1 0 1 0 2  c001 00

/* sim/tb_lab7.sv */
module tb_lab7;

    localparam int SCAN_DIV      = 4;
    localparam int STABLE_TICKS  = 3;
    localparam int DIGITS        = lab7_pkg::digits_n;
    localparam int HEX_DIGITS    = lab7_pkg::data_w / 4;
    localparam int N_TESTS       = 15;
    localparam int N_FIELDS      = 8;
    localparam int N_BUTTONS     = 5;
    localparam int HOLD_TICKS    = 6;
    localparam int RELEASE_TICKS = 6;
    localparam int GAP_TICKS     = 2;
    localparam int CYCLE_LIMIT   = N_TESTS * 2000 + 200;

    // Lit segments gfedcba for 0 to F, inverted for the board
    localparam logic [6:0] SEG_ON [16] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
    };

    logic                        clk;
    logic                        arst_n;
    logic [lab7_pkg::data_w-1:0] sw;
    lab7_pkg::btn_t              btn;
    lab7_pkg::led_t              led;
    logic [DIGITS-1:0]           an;
    lab7_pkg::seg_t              seg;

    // Eight words per test, see the data file header
    logic [15:0] pat_mem [0:N_TESTS*N_FIELDS-1];

    // Expected control state
    logic       m_dir;
    logic       m_rot;
    logic       m_sh0;
    logic       m_sh1;
    logic [1:0] m_centre;

    int cycle_cnt = 0;

    lab7_top #(
        .SCAN_DIV    (SCAN_DIV),
        .STABLE_TICKS(STABLE_TICKS)
    ) uut (
        .clk   (clk),
        .arst_n(arst_n),
        .sw    (sw),
        .btn   (btn),
        .led   (led),
        .an    (an),
        .seg   (seg)
    );

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic abort_run(input string why);
        $display("TB FAILED");
        $fatal(1, "%s", why);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            abort_run($sformatf("Timeout, run still busy after %0d cycles", cycle_cnt));
        end
    end

    task automatic check_led(input lab7_pkg::led_t got, input lab7_pkg::led_t exp,
                             input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s, led %h expected %h", $time, what, got, exp);
            abort_run("LED value mismatch");
        end
    endtask

    task automatic check_digit(input lab7_pkg::seg_t got, input lab7_pkg::seg_t exp,
                               input int digit);
        if (got !== exp) begin
            $display("[ERROR] %0t: digit %0d seg %b expected %b", $time, digit, got, exp);
            abort_run("Segment pattern mismatch");
        end
    endtask

    task automatic check_anodes(input logic [DIGITS-1:0] got, input logic [DIGITS-1:0] exp,
                                input int digit);
        if (got !== exp) begin
            $display("[ERROR] %0t: step to digit %0d an %b expected %b", $time, digit, got, exp);
            abort_run("Anode pattern mismatch");
        end
    endtask

    function automatic lab7_pkg::seg_t segments_for(input logic [3:0] nib);
        return ~SEG_ON[nib];
    endfunction

    // LED layout is two zeros, shamt, rotate, dir
    function automatic lab7_pkg::led_t model_led();
        return {2'b00, m_centre, m_sh1, m_sh0, m_rot, m_dir};
    endfunction

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Short bounces first, each sampled by at most one tick
    task automatic press_button(input logic [2:0] bit_idx);
        int n_glitch;
        int hi_len;
        int lo_len;
        n_glitch = 1 + int'($urandom % 3);
        @(posedge clk);
        for (int g = 0; g < n_glitch; g++) begin
            hi_len = 1 + int'($urandom % 3);
            lo_len = SCAN_DIV + int'($urandom % 4);
            btn[bit_idx] <= 1'b1;
            wait_cycles(hi_len);
            btn[bit_idx] <= 1'b0;
            wait_cycles(lo_len);
        end
        btn[bit_idx] <= 1'b1;
        wait_cycles(HOLD_TICKS * SCAN_DIV);
        btn[bit_idx] <= 1'b0;
        wait_cycles((RELEASE_TICKS + GAP_TICKS) * SCAN_DIV);
    endtask

    // Field order up, down, left, right, centre
    task automatic apply_model(input int field);
        case (field)
            0: m_dir = ~m_dir;
            1: m_rot = ~m_rot;
            2: m_sh0 = ~m_sh0;
            3: m_sh1 = ~m_sh1;
            default: m_centre = m_centre + 2'd1;
        endcase
    endtask

    // Follows eight anode steps, one per scan tick, and checks each digit
    task automatic check_display(input logic [lab7_pkg::data_w-1:0] word);
        logic [DIGITS-1:0] prev_an;
        logic [DIGITS-1:0] exp_an;
        lab7_pkg::seg_t    exp_seg;
        int                k;
        int                gap;
        k = 0;
        @(negedge clk);
        prev_an = an;
        for (int t = 0; t < DIGITS; t++) begin
            gap = 1;
            @(negedge clk);
            while (an == prev_an) begin
                @(negedge clk);
                gap++;
            end
            prev_an = an;
            if (t > 0 && gap != SCAN_DIV) begin
                abort_run($sformatf("Anode step after %0d cycles instead of one scan tick",
                                    gap));
            end
            if (t == 0) begin
                for (int b = DIGITS - 1; b >= 0; b--) begin
                    if (((an >> b) & DIGITS'(1)) == DIGITS'(0)) begin
                        k = b;
                    end
                end
            end else begin
                k = (k + 1) % DIGITS;
            end
            exp_an = ~(DIGITS'(1) << k);
            check_anodes(an, exp_an, k);
            if (k < HEX_DIGITS) begin
                exp_seg = segments_for(4'(word >> (4 * k)));
            end else begin
                exp_seg = lab7_pkg::seg_blank;
            end
            check_digit(seg, exp_seg, k);
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int             base;
        int             n_press;
        lab7_pkg::led_t file_led;
        void'($urandom(27355));
        arst_n   <= 1'b0;
        sw       <= '0;
        btn      <= '0;
        m_dir    = 1'b0;
        m_rot    = 1'b0;
        m_sh0    = 1'b0;
        m_sh1    = 1'b0;
        m_centre = 2'd0;
        $readmemh("sim/lab7_patterns.txt", pat_mem);

        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        // Display stays dark until the first tick
        @(negedge clk);
        check_led(led, 8'h00, "after reset");
        check_anodes(an, '1, 0);
        check_digit(seg, lab7_pkg::seg_blank, 0);

        for (int t = 0; t < N_TESTS; t++) begin
            base = t * N_FIELDS;
            @(posedge clk);
            sw <= pat_mem[base];
            for (int f = 0; f < N_BUTTONS; f++) begin
                n_press = int'(pat_mem[base + 1 + f]);
                for (int p = 0; p < n_press; p++) begin
                    press_button(3'(N_BUTTONS - 1 - f));
                    apply_model(f);
                    @(negedge clk);
                    check_led(led, model_led(), $sformatf("test %0d press on field %0d", t, f));
                end
            end
            file_led = pat_mem[base + 7][7:0];
            if (file_led != model_led()) begin
                abort_run($sformatf("Pattern line %0d has an LED column the presses cannot give", t));
            end
            check_led(led, model_led(), $sformatf("test %0d end", t));
            check_display(pat_mem[base + 6]);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

/* sources.f */
verilog/lab7_pkg.sv
verilog/tick_divider.sv
verilog/button_conditioner.sv
verilog/shift_control.sv
verilog/barrel_shifter16.sv
verilog/seg7_scan8.sv
verilog/lab7_top.sv
sim/tb_lab7.sv

/* verilog/barrel_shifter16.sv */
module barrel_shifter16 (
    input  logic [lab7_pkg::data_w-1:0] data_in,
    input  lab7_pkg::shift_ctrl_t       ctrl,
    output logic [lab7_pkg::data_w-1:0] data_out
);

    localparam int W      = lab7_pkg::data_w;
    localparam int STAGES = $bits(lab7_pkg::shamt_t);

    // Stage s moves by 2**s when shamt bit s is set
    logic [STAGES:0][W-1:0] stage;

    assign stage[0] = data_in;

    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        localparam int AMT = 1 << s;

        logic [W-1:0] wrap_l;
        logic [W-1:0] wrap_r;
        logic [W-1:0] moved;

        // Bits that fall off one end, kept only for rotate
        assign wrap_l = ctrl.rotate ? (stage[s] >> (W - AMT)) : '0;
        assign wrap_r = ctrl.rotate ? (stage[s] << (W - AMT)) : '0;

        always_comb begin
            if (ctrl.dir) begin
                moved = (stage[s] >> AMT) | wrap_r;
            end else begin
                moved = (stage[s] << AMT) | wrap_l;
            end
        end

        assign stage[s+1] = ctrl.shamt[s] ? moved : stage[s];
    end

    assign data_out = stage[STAGES];

endmodule

/* verilog/button_conditioner.sv */
module button_conditioner #(
    parameter int STABLE_TICKS = 10
) (
    input  logic clk,
    input  logic arst_n,
    input  logic scan_tick,
    input  logic raw,
    output logic press
);

    localparam int CNT_W = $clog2(STABLE_TICKS + 1);

    logic [1:0]       sync_q;
    logic [CNT_W-1:0] stable_cnt;
    logic             state_q;
    logic             state_d1;

    // Two-flop synchronizer on the raw pin
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], raw};
        end
    end

    //////////////////////////////
    // Debounce
    //////////////////////////////

    // Count samples that disagree with the debounced state,
    // any agreeing sample restarts the run
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stable_cnt <= '0;
            state_q    <= 1'b0;
        end else if (scan_tick) begin
            if (sync_q[1] == state_q) begin
                stable_cnt <= '0;
            end else if (stable_cnt == CNT_W'(STABLE_TICKS - 1)) begin
                stable_cnt <= '0;
                state_q    <= sync_q[1];
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_d1 <= 1'b0;
        end else begin
            state_d1 <= state_q;
        end
    end

    // Rising edge of the debounced level
    assign press = state_q & ~state_d1;

    a_press_single : assert property (
        @(posedge clk) disable iff (!arst_n)
        press |=> !press
    );

endmodule

/* verilog/lab7_pkg.sv */
package lab7_pkg;

    //////////////////////////////
    // Widths and codes
    //////////////////////////////

    // Data word from the switches
    localparam int data_w = 16;

    // Eight digits on the board, four of them used
    localparam int digits_n = 8;

    typedef logic [3:0] shamt_t;

    // Active low, bit 0 is segment a, bit 6 is segment g
    typedef logic [6:0] seg_t;

    localparam seg_t seg_blank = 7'b111_1111;

    typedef logic [7:0] led_t;

    //////////////////////////////
    // Grouped signals
    //////////////////////////////

    // One bit per push button, raw levels or press pulses
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic centre;
    } btn_t;

    // Field order matches the low six LED bits
    typedef struct packed {
        shamt_t shamt;
        logic   rotate;  // 0 logical, 1 rotate
        logic   dir;     // 0 left, 1 right
    } shift_ctrl_t;

endpackage

/* verilog/lab7_top.sv */
module lab7_top #(
    parameter int SCAN_DIV     = 100000,
    parameter int STABLE_TICKS = 10
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [lab7_pkg::data_w-1:0]   sw,
    input  lab7_pkg::btn_t                btn,
    output lab7_pkg::led_t                led,
    output logic [lab7_pkg::digits_n-1:0] an,
    output lab7_pkg::seg_t                seg
);

    localparam int N_BTN = $bits(lab7_pkg::btn_t);

    logic                        scan_tick;
    lab7_pkg::btn_t              press;
    lab7_pkg::shift_ctrl_t       ctrl;
    logic [lab7_pkg::data_w-1:0] shifted;

    // Common pace for debounce and scanning
    tick_divider #(
        .SCAN_DIV(SCAN_DIV)
    ) u_tick (
        .clk      (clk),
        .arst_n   (arst_n),
        .scan_tick(scan_tick)
    );

    //////////////////////////////
    // Buttons
    //////////////////////////////

    // One conditioner per struct field, bit order follows btn_t
    for (genvar i = 0; i < N_BTN; i++) begin : g_btn
        button_conditioner #(
            .STABLE_TICKS(STABLE_TICKS)
        ) u_cond (
            .clk      (clk),
            .arst_n   (arst_n),
            .scan_tick(scan_tick),
            .raw      (btn[i]),
            .press    (press[i])
        );
    end

    shift_control u_ctrl (
        .clk   (clk),
        .arst_n(arst_n),
        .press (press),
        .ctrl  (ctrl),
        .led   (led)
    );

    //////////////////////////////
    // Datapath and display
    //////////////////////////////

    barrel_shifter16 u_shift (
        .data_in (sw),
        .ctrl    (ctrl),
        .data_out(shifted)
    );

    seg7_scan8 u_scan (
        .clk      (clk),
        .arst_n   (arst_n),
        .scan_tick(scan_tick),
        .value    (shifted),
        .an       (an),
        .seg      (seg)
    );

endmodule

/* verilog/seg7_scan8.sv */
module seg7_scan8 (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          scan_tick,
    input  logic [lab7_pkg::data_w-1:0]   value,
    output logic [lab7_pkg::digits_n-1:0] an,
    output lab7_pkg::seg_t                seg
);

    localparam int IDX_W      = $clog2(lab7_pkg::digits_n);
    localparam int HEX_DIGITS = lab7_pkg::data_w / 4;

    logic [IDX_W-1:0]             idx;
    logic [3:0]                   nibble;
    lab7_pkg::seg_t               seg_next;
    logic [lab7_pkg::digits_n-1:0] an_next;

    // Active-low hex patterns, gfedcba
    function automatic lab7_pkg::seg_t hex_to_seg(input logic [3:0] h);
        case (h)
            4'h0: hex_to_seg = 7'b100_0000;
            4'h1: hex_to_seg = 7'b111_1001;
            4'h2: hex_to_seg = 7'b010_0100;
            4'h3: hex_to_seg = 7'b011_0000;
            4'h4: hex_to_seg = 7'b001_1001;
            4'h5: hex_to_seg = 7'b001_0010;
            4'h6: hex_to_seg = 7'b000_0010;
            4'h7: hex_to_seg = 7'b111_1000;
            4'h8: hex_to_seg = 7'b000_0000;
            4'h9: hex_to_seg = 7'b001_0000;
            4'ha: hex_to_seg = 7'b000_1000;
            4'hb: hex_to_seg = 7'b000_0011;
            4'hc: hex_to_seg = 7'b100_0110;
            4'hd: hex_to_seg = 7'b010_0001;
            4'he: hex_to_seg = 7'b000_0110;
            default: hex_to_seg = 7'b000_1110;
        endcase
    endfunction

    //////////////////////////////
    // Digit select
    //////////////////////////////

    assign nibble = 4'(value >> {idx, 2'b00});

    always_comb begin
        an_next      = '1;
        an_next[idx] = 1'b0;
        if (idx < IDX_W'(HEX_DIGITS)) begin
            seg_next = hex_to_seg(nibble);
        end else begin
            // Upper digits stay dark
            seg_next = lab7_pkg::seg_blank;
        end
    end

    // Anode and pattern change on the same edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idx <= '0;
            an  <= '1;
            seg <= lab7_pkg::seg_blank;
        end else if (scan_tick) begin
            idx <= idx + 1'b1;
            an  <= an_next;
            seg <= seg_next;
        end
    end

    // Never drive two digits at once
    a_one_anode : assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(~an)
    );

endmodule

/* verilog/shift_control.sv */
module shift_control (
    input  logic                   clk,
    input  logic                   arst_n,
    input  lab7_pkg::btn_t         press,
    output lab7_pkg::shift_ctrl_t  ctrl,
    output lab7_pkg::led_t         led
);

    logic       dir_q;
    logic       rot_q;
    logic       sh0_q;
    logic       sh1_q;
    logic [1:0] centre_cnt;

    //////////////////////////////
    // Toggles
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dir_q <= 1'b0;
            rot_q <= 1'b0;
            sh0_q <= 1'b0;
            sh1_q <= 1'b0;
        end else begin
            if (press.up) begin
                dir_q <= ~dir_q;
            end
            if (press.down) begin
                rot_q <= ~rot_q;
            end
            if (press.left) begin
                sh0_q <= ~sh0_q;
            end
            if (press.right) begin
                sh1_q <= ~sh1_q;
            end
        end
    end

    // Upper shift bits, wraps 3 to 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            centre_cnt <= 2'd0;
        end else if (press.centre) begin
            centre_cnt <= centre_cnt + 2'd1;
        end
    end

    assign ctrl.dir    = dir_q;
    assign ctrl.rotate = rot_q;
    assign ctrl.shamt  = {centre_cnt, sh1_q, sh0_q};

    // Two unused LEDs, then shamt, rotate, dir
    assign led = {2'b00, ctrl};

endmodule

/* verilog/tick_divider.sv */
module tick_divider #(
    parameter int SCAN_DIV = 100000
) (
    input  logic clk,
    input  logic arst_n,
    output logic scan_tick
);

    localparam int CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [CNT_W-1:0] cnt;

    // Wraps at SCAN_DIV-1, tick follows on the next edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt       <= '0;
            scan_tick <= 1'b0;
        end else begin
            if (cnt == CNT_W'(SCAN_DIV - 1)) begin
                cnt       <= '0;
                scan_tick <= 1'b1;
            end else begin
                cnt       <= cnt + 1'b1;
                scan_tick <= 1'b0;
            end
        end
    end

    // Debounce and scan both rely on single-cycle ticks
    a_tick_single : assert property (
        @(posedge clk) disable iff (!arst_n)
        scan_tick |=> !scan_tick
    );

endmodule
